//--- rtl/decodePkg.sv
/*
 * Types and encodings shared by the 40-bit instruction decode stage
 * Only the listed ISA subset is recognised and anything else decodes as illegal
 * Specifiers are 6 bits wide: 0..31 general, 32..39 predicate, 46 always true
 */
package decodePkg;

	// ==================================================================
	// Register specifiers
	// ==================================================================

	typedef logic [5:0] regspec_t;

	// Register 0 stands for "no register" in every specifier slot
	localparam regspec_t REG_NONE = 6'd0;

	// Predicate used when an instruction names none, always true
	localparam regspec_t PRED_NONE = 6'd46;

	// Upper bits of a predicate specifier, giving the bank at 32..39
	localparam logic [2:0] PRED_BANK = 3'b100;

	// ==================================================================
	// Opcodes and R2 function codes
	// ==================================================================

	typedef enum logic [6:0] {
		OP_NOP  = 7'd31,
		OP_R2   = 7'd2,
		OP_ADDI = 7'd4,
		OP_ANDI = 7'd8,
		OP_ORI  = 7'd9,
		OP_CMPI = 7'd11,
		OP_MOV  = 7'd12,
		OP_JSR  = 7'd32,
		OP_LDW  = 7'd66
	} opcode_t;

	typedef enum logic [5:0] {
		FN_ADD = 6'd4,
		FN_SUB = 6'd5,
		FN_AND = 6'd8,
		FN_OR  = 6'd9,
		FN_EOR = 6'd10,
		FN_CMP = 6'd11,
		FN_MUL = 6'd12,
		FN_SLT = 6'd18
	} func_t;

	// ==================================================================
	// Instruction layout
	// ==================================================================

	// Opcode only, for the first level of decode
	typedef struct packed {
		logic [32:0] payload;
		opcode_t     opcode;
	} instrAny_t;

	// Register to register form, also used by MOV
	typedef struct packed {
		logic [2:0] padHi;
		logic [2:0] pred;   // bits 36..34
		logic [2:0] padLo;
		func_t      func;   // bits 30..25
		regspec_t   rb;     // bits 24..19
		regspec_t   ra;     // bits 18..13
		regspec_t   rt;     // bits 12..7
		opcode_t    opcode;
	} instrR2_t;

	// Immediate form, shared by the ALU immediates, LDW and JSR
	typedef struct packed {
		logic [1:0]  padHi;
		logic [2:0]  pred;  // bits 37..35
		logic [15:0] imm;   // bits 34..19
		regspec_t    ra;
		regspec_t    rt;
		opcode_t     opcode;
	} instrRi_t;

	typedef union packed {
		instrAny_t any;
		instrR2_t  r2;
		instrRi_t  ri;
	} instruction_t;

	// Class flags carried down the pipe with each instruction
	typedef struct packed {
		logic isAlu;
		logic isLoad;
		logic isJump;
		logic useImm;
	} insnClass_t;

endpackage

//--- rtl/decodeIf.sv
/*
 * Decoded fields passed from the combinational decoder to the stage register
 * Every signal is combinational from the instruction word
 */
interface decodeIf
	import decodePkg::*;
#(
	parameter int immWidth = 32
);

	// Destination, sources and predicate specifiers
	regspec_t rt;
	regspec_t ra;
	regspec_t rb;
	regspec_t rp;

	// Sign-extended immediate, zero when the form has none
	logic [immWidth-1:0] imm;

	insnClass_t cls;

	// Unknown opcode or unknown R2 function
	logic illegal;

	// The decoder drives every field
	modport source (output rt, ra, rb, rp, imm, cls, illegal);

	// The stage register only samples them
	modport sink (input rt, ra, rb, rp, imm, cls, illegal);

endinterface

//--- rtl/decodePredReg.sv
/*
 * Predicate register specifier decode
 * R2 and MOV carry the predicate in bits 36..34, the immediate forms in 37..35
 * NOP, unknown opcodes and unknown R2 functions get the always-true predicate
 */
module decodePredReg
	import decodePkg::*;
(
	input  instruction_t instr,
	output regspec_t     rp
);

	// Specifier built from the R2 predicate field
	regspec_t predR2;

	// Specifier built from the immediate-form predicate field
	regspec_t predRi;

	// Both positions are formed up front and the opcode only picks one
	assign predR2 = {PRED_BANK, instr.r2.pred};
	assign predRi = {PRED_BANK, instr.ri.pred};

	always_comb
	begin
		rp = PRED_NONE;
		case (instr.any.opcode)
			OP_R2:
			begin
				// Only the supported functions are predicated
				case (instr.r2.func)
					FN_ADD, FN_SUB, FN_AND, FN_OR,
					FN_EOR, FN_CMP, FN_MUL, FN_SLT:
						rp = predR2;
					default:
						rp = PRED_NONE;
				endcase
			end
			// MOV reuses the R2 layout
			OP_MOV:
				rp = predR2;
			OP_ADDI, OP_ANDI, OP_ORI, OP_CMPI, OP_LDW, OP_JSR:
				rp = predRi;
			// NOP and anything not recognised run unconditionally
			default:
				rp = PRED_NONE;
		endcase
	end

endmodule

//--- rtl/decodeRegSpec.sv
/*
 * Destination and source register specifier decode
 * Fields an instruction does not use read as REG_NONE, as do all fields
 * of an unknown opcode or an unknown R2 function
 */
module decodeRegSpec
	import decodePkg::*;
(
	input  instruction_t instr,
	output regspec_t     rt,
	output regspec_t     ra,
	output regspec_t     rb
);

	// ==================================================================
	// Which register fields are meaningful for each opcode
	// ==================================================================

	always_comb
	begin
		// Start from "no register" so that any path not listed stays clean
		rt = REG_NONE;
		ra = REG_NONE;
		rb = REG_NONE;
		case (instr.any.opcode)
			OP_R2:
			begin
				// Two sources and a destination for every supported function
				case (instr.r2.func)
					FN_ADD, FN_SUB, FN_AND, FN_OR,
					FN_EOR, FN_CMP, FN_MUL, FN_SLT:
					begin
						rt = instr.r2.rt;
						ra = instr.r2.ra;
						rb = instr.r2.rb;
					end
					// An unknown function must not create false dependencies
					default:
					begin
						rt = REG_NONE;
						ra = REG_NONE;
						rb = REG_NONE;
					end
				endcase
			end
			OP_MOV:
			begin
				// Single source copy, the Rb slot is ignored
				rt = instr.r2.rt;
				ra = instr.r2.ra;
			end
			OP_ADDI, OP_ANDI, OP_ORI, OP_CMPI, OP_LDW:
			begin
				// Ra is the ALU operand or the load base register
				rt = instr.ri.rt;
				ra = instr.ri.ra;
			end
			OP_JSR:
			begin
				// Only the link register is written, the target is immediate
				rt = instr.ri.rt;
			end
			default:
			begin
				rt = REG_NONE;
				ra = REG_NONE;
				rb = REG_NONE;
			end
		endcase
	end

endmodule

//--- rtl/decodeFields.sv
/*
 * Combinational field decode for one instruction word
 * Joins the specifier decoders with class flags, immediate and illegal detection
 * immWidth must be 16 or more since the immediate is sign-extended to it
 */
module decodeFields
	import decodePkg::*;
#(
	parameter int immWidth = 32
)
(
	input  instruction_t   instr,
	decodeIf.source        fields
);

	regspec_t            rt;
	regspec_t            ra;
	regspec_t            rb;
	regspec_t            rp;
	insnClass_t          cls;
	logic                illegal;
	logic [immWidth-1:0] immExt;

	// ==================================================================
	// Specifier decoders
	// ==================================================================

	decodeRegSpec decodeRegSpec_i (
		.instr (instr),
		.rt    (rt),
		.ra    (ra),
		.rb    (rb)
	);

	decodePredReg decodePredReg_i (
		.instr (instr),
		.rp    (rp)
	);

	// ==================================================================
	// Class, immediate and validity
	// ==================================================================

	// Sign extension of the 16-bit immediate field
	assign immExt = immWidth'(signed'(instr.ri.imm));

	always_comb
	begin
		cls     = '0;
		illegal = 1'b0;
		case (instr.any.opcode)
			OP_R2:
			begin
				case (instr.r2.func)
					FN_ADD, FN_SUB, FN_AND, FN_OR,
					FN_EOR, FN_CMP, FN_MUL, FN_SLT:
						cls.isAlu = 1'b1;
					default:
						illegal = 1'b1;
				endcase
			end
			OP_MOV:
				cls.isAlu = 1'b1;
			OP_ADDI, OP_ANDI, OP_ORI, OP_CMPI:
			begin
				cls.isAlu  = 1'b1;
				cls.useImm = 1'b1;
			end
			OP_LDW:
			begin
				// Displacement from Ra
				cls.isLoad = 1'b1;
				cls.useImm = 1'b1;
			end
			OP_JSR:
			begin
				cls.isJump = 1'b1;
				cls.useImm = 1'b1;
			end
			// NOP is valid and simply has no class
			OP_NOP:
				cls = '0;
			default:
				illegal = 1'b1;
		endcase
	end

	assign fields.rt      = rt;
	assign fields.ra      = ra;
	assign fields.rb      = rb;
	assign fields.rp      = rp;
	assign fields.cls     = cls;
	assign fields.illegal = illegal;

	// Forms without an immediate pass zero so stale bits never leak through
	assign fields.imm = cls.useImm ? immExt : '0;

endmodule

//--- rtl/decodeStage.sv
/*
 * Decode pipeline register with stall and a read-after-write hazard flag
 * One cycle latency from an accepted instruction to outValid
 * imm has no reset and is undefined until the first capture
 */
module decodeStage
	import decodePkg::*;
#(
	parameter int immWidth = 32
)
(
	input  logic                clk,
	input  logic                rstN,
	input  logic                instrValid,
	input  logic                stall,
	decodeIf.sink               fields,
	output logic                outValid,
	output regspec_t            rt,
	output regspec_t            ra,
	output regspec_t            rb,
	output regspec_t            rp,
	output logic [immWidth-1:0] imm,
	output logic                isAlu,
	output logic                isLoad,
	output logic                isJump,
	output logic                useImm,
	output logic                illegal,
	output logic                hazard
);

	logic       capture;
	logic       hazardNext;
	regspec_t   lastRt;
	insnClass_t clsQ;

	// An instruction is taken only out of reset and with no stall
	assign capture = rstN && instrValid && !stall;

	// Compare against the destination of the last captured instruction
	// REG_NONE never counts, so illegal and NOP producers are harmless
	assign hazardNext = (lastRt != REG_NONE) &&
		((lastRt == fields.ra) || (lastRt == fields.rb));

	// ==================================================================
	// Control and specifier registers
	// ==================================================================

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			outValid <= 1'b0;
			hazard   <= 1'b0;
			illegal  <= 1'b0;
			rt       <= REG_NONE;
			ra       <= REG_NONE;
			rb       <= REG_NONE;
			rp       <= REG_NONE;
			clsQ     <= '0;
			lastRt   <= REG_NONE;
		end
		else if (!stall)
		begin
			outValid <= instrValid;
			// Hazard is only meaningful alongside a valid output
			hazard   <= capture && hazardNext;
			if (capture)
			begin
				rt      <= fields.rt;
				ra      <= fields.ra;
				rb      <= fields.rb;
				rp      <= fields.rp;
				clsQ    <= fields.cls;
				illegal <= fields.illegal;
				// Idle gaps leave the tracked destination in place
				lastRt  <= fields.rt;
			end
		end
	end

	// Immediate payload follows the same capture
	always_ff @(posedge clk)
	begin
		if (capture)
			imm <= fields.imm;
	end

	assign isAlu  = clsQ.isAlu;
	assign isLoad = clsQ.isLoad;
	assign isJump = clsQ.isJump;
	assign useImm = clsQ.useImm;

endmodule

//--- rtl/decodeTop.sv
/*
 * Decode stage top level with plain ports
 * instr must be held by the source while stall is high
 */
module decodeTop
	import decodePkg::*;
#(
	parameter int immWidth = 32
)
(
	input  logic                clk,
	input  logic                rstN,
	input  logic [39:0]         instr,
	input  logic                instrValid,
	input  logic                stall,
	output logic                outValid,
	output regspec_t            rt,
	output regspec_t            ra,
	output regspec_t            rb,
	output regspec_t            rp,
	output logic [immWidth-1:0] imm,
	output logic                isAlu,
	output logic                isLoad,
	output logic                isJump,
	output logic                useImm,
	output logic                illegal,
	output logic                hazard
);

	// Decoded fields between the combinational decoder and the register
	decodeIf #(.immWidth(immWidth)) fieldsIf ();

	decodeFields #(.immWidth(immWidth)) decodeFields_i (
		.instr  (instr),
		.fields (fieldsIf.source)
	);

	decodeStage #(.immWidth(immWidth)) decodeStage_i (
		.clk        (clk),
		.rstN       (rstN),
		.instrValid (instrValid),
		.stall      (stall),
		.fields     (fieldsIf.sink),
		.outValid   (outValid),
		.rt         (rt),
		.ra         (ra),
		.rb         (rb),
		.rp         (rp),
		.imm        (imm),
		.isAlu      (isAlu),
		.isLoad     (isLoad),
		.isJump     (isJump),
		.useImm     (useImm),
		.illegal    (illegal),
		.hazard     (hazard)
	);

endmodule

//--- verif/decodeChecker.sv
/*
 * Concurrent checks on the decode stage register, bound into decodeStage
 * imm is unreset, so stall must not be raised before the first capture
 */
module decodeChecker
#(
	parameter int immWidth = 32
)
(
	input logic                clk,
	input logic                rstN,
	input logic                stall,
	input logic                outValid,
	input logic [5:0]          rt,
	input logic [5:0]          ra,
	input logic [5:0]          rb,
	input logic [5:0]          rp,
	input logic [immWidth-1:0] imm,
	input logic                isAlu,
	input logic                isLoad,
	input logic                isJump,
	input logic                useImm,
	input logic                illegal,
	input logic                hazard
);

	// A reset edge always leaves the stage empty
	resetClearsValid: assert property (@(posedge clk) !rstN |=> !outValid)
		else $error("outValid high in the cycle after reset");

	// A stalled edge must not move any output
	stallHolds: assert property (@(posedge clk) disable iff (!rstN)
		stall |=> $stable({outValid, rt, ra, rb, rp, imm, isAlu, isLoad,
			isJump, useImm, illegal, hazard}))
		else $error("Outputs changed across a stalled cycle");

	hazardNeedsValid: assert property (@(posedge clk) hazard |-> outValid)
		else $error("hazard set without outValid");

	// Illegal encodings carry no class at all
	illegalNoClass: assert property (@(posedge clk)
		illegal |-> !(isAlu || isLoad || isJump || useImm))
		else $error("Class flag set on an illegal instruction");

endmodule

bind decodeStage decodeChecker #(.immWidth(immWidth)) decodeChecker_i (.*);

//--- verif/decodeTb.sv
/*
 * File-driven testbench for the decode stage top level
 * Lines of the stimulus file are driven one per cycle and checked one cycle later
 * A random NOP filler between tests clears the hazard tracker
 */
module decodeTb
	import decodePkg::*;
();

	localparam int maxLines = 200;
	localparam int resetTimeout = 10;

	logic        clk;
	logic        rstN;
	logic [39:0] instr;
	logic        instrValid;
	logic        stall;
	logic        outValid;
	logic [5:0]  rt;
	logic [5:0]  ra;
	logic [5:0]  rb;
	logic [5:0]  rp;
	logic [31:0] imm;
	logic        isAlu;
	logic        isLoad;
	logic        isJump;
	logic        useImm;
	logic        illegal;
	logic        hazard;

	integer      seed;
	integer      fd;
	integer      scanCount;
	integer      lineCount;
	integer      waitCount;
	integer      testNumber;
	integer      testErrors;
	integer      testsFailed;
	integer      totalErrors;
	logic        aborted;
	logic        havePrev;
	string       line;
	string       sigNames [12];
	logic [31:0] tag;
	logic [31:0] inValid;
	logic [31:0] inStall;
	logic [39:0] inInstr;
	logic [31:0] curExp [12];
	logic [31:0] chkExp [12];

	decodeTop #(.immWidth(32)) decodeTop_i (
		.clk        (clk),
		.rstN       (rstN),
		.instr      (instr),
		.instrValid (instrValid),
		.stall      (stall),
		.outValid   (outValid),
		.rt         (rt),
		.ra         (ra),
		.rb         (rb),
		.rp         (rp),
		.imm        (imm),
		.isAlu      (isAlu),
		.isLoad     (isLoad),
		.isJump     (isJump),
		.useImm     (useImm),
		.illegal    (illegal),
		.hazard     (hazard)
	);

	always #10 clk = ~clk;

	// ==================================================================
	// Checking helpers
	// ==================================================================

	task automatic compareValue(input string name, input logic [31:0] e, input logic [31:0] a);
	begin
		assert (a === e)
		else
		begin
			$display("FAILED test %0d: %s expected %h got %h", testNumber, name, e, a);
			testErrors = testErrors + 1;
		end
	end
	endtask

	// Compares every output with the row held in chkExp
	task automatic compareOutputs();
	begin
		compareValue(sigNames[0], chkExp[0], 32'(outValid));
		compareValue(sigNames[1], chkExp[1], 32'(rt));
		compareValue(sigNames[2], chkExp[2], 32'(ra));
		compareValue(sigNames[3], chkExp[3], 32'(rb));
		compareValue(sigNames[4], chkExp[4], 32'(rp));
		compareValue(sigNames[5], chkExp[5], imm);
		compareValue(sigNames[6], chkExp[6], 32'(isAlu));
		compareValue(sigNames[7], chkExp[7], 32'(isLoad));
		compareValue(sigNames[8], chkExp[8], 32'(isJump));
		compareValue(sigNames[9], chkExp[9], 32'(useImm));
		compareValue(sigNames[10], chkExp[10], 32'(illegal));
		compareValue(sigNames[11], chkExp[11], 32'(hazard));
	end
	endtask

	task automatic finishTest();
	begin
		if (testErrors == 0)
			$display("Test %0d finished with no mismatches", testNumber);
		else
		begin
			$display("Test %0d finished with %0d mismatches", testNumber, testErrors);
			testsFailed = testsFailed + 1;
		end
		totalErrors = totalErrors + testErrors;
		testErrors = 0;
		testNumber = testNumber + 1;
	end
	endtask

	// ==================================================================
	// Main sequence
	// ==================================================================

	initial
	begin
		sigNames = '{"outValid", "rt", "ra", "rb", "rp", "imm", "isAlu", "isLoad",
			"isJump", "useImm", "illegal", "hazard"};
		seed = 60;
		clk = 1'b0;
		rstN = 1'b0;
		instr = '0;
		instrValid = 1'b0;
		stall = 1'b0;
		testNumber = 0;
		testErrors = 0;
		testsFailed = 0;
		totalErrors = 0;
		aborted = 1'b0;
		havePrev = 1'b0;
		lineCount = 0;
		waitCount = 0;

		// Reset is held low across three rising edges
		repeat (3) @(posedge clk);
		rstN <= 1'b1;

		// The stage must report itself empty once reset has taken effect
		while (outValid !== 1'b0 && waitCount < resetTimeout)
		begin
			@(posedge clk);
			waitCount = waitCount + 1;
		end
		if (outValid !== 1'b0)
		begin
			$display("outValid still not low %0d cycles after reset", resetTimeout);
			aborted = 1'b1;
		end

		// Test 0 checks the reset values of every output that has one
		@(negedge clk);
		compareValue("outValid", 32'd0, 32'(outValid));
		compareValue("hazard", 32'd0, 32'(hazard));
		compareValue("illegal", 32'd0, 32'(illegal));
		compareValue("rt", 32'(REG_NONE), 32'(rt));
		compareValue("ra", 32'(REG_NONE), 32'(ra));
		compareValue("rb", 32'(REG_NONE), 32'(rb));
		compareValue("rp", 32'(REG_NONE), 32'(rp));
		finishTest();

		fd = $fopen("verif/decodeInput.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the stimulus file");
			aborted = 1'b1;
		end

		while (!aborted && !$feof(fd))
		begin
			lineCount = lineCount + 1;
			if (lineCount > maxLines)
			begin
				$display("Stimulus file longer than %0d lines", maxLines);
				aborted = 1'b1;
			end
			else if ($fgets(line, fd) > 1 && line.getc(0) != 8'h23)
			begin
				scanCount = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					tag, inInstr, inValid, inStall, curExp[0], curExp[1], curExp[2],
					curExp[3], curExp[4], curExp[5], curExp[6], curExp[7], curExp[8],
					curExp[9], curExp[10], curExp[11]);
				if (scanCount != 16)
				begin
					$display("Malformed stimulus line %0d", lineCount);
					totalErrors = totalErrors + 1;
				end
				else
				begin
					@(posedge clk);
					instr <= inInstr;
					instrValid <= inValid[0];
					stall <= inStall[0];
					// The row driven one edge earlier is now visible at the outputs
					@(negedge clk);
					if (havePrev)
						compareOutputs();
					chkExp = curExp;
					havePrev = 1'b1;
					if (tag[0])
					begin
						// A captured NOP with a random payload leaves no tracked destination
						@(posedge clk);
						instr <= {$random(seed), 1'b1, OP_NOP};
						instrValid <= 1'b1;
						stall <= 1'b0;
						@(negedge clk);
						compareOutputs();
						havePrev = 1'b0;
						finishTest();
					end
				end
			end
		end

		// A file ending without an end marker still gets its last row checked
		if (havePrev)
		begin
			@(posedge clk);
			instrValid <= 1'b0;
			stall <= 1'b0;
			@(negedge clk);
			compareOutputs();
			finishTest();
		end
		if (fd != 0)
			$fclose(fd);

		$display("Tests run: %0d, failed: %0d, mismatches: %0d", testNumber, testsFailed,
			totalErrors);
		if (totalErrors == 0 && !aborted)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- verif/decodeInput.txt
# tag(1=last row of test) instr valid stall | expected next cycle:
# outValid rt ra rb rp imm isAlu isLoad isJump useImm illegal hazard
0 1408102182 1 0 1 03 01 02 25 00000000 1 0 0 0 0 0
0 1C24616502 1 0 1 0a 0b 0c 27 00000000 1 0 0 0 0 0
1 0800B2AA0C 1 0 1 14 15 00 22 00000000 1 0 0 0 0 0
0 1891A0C284 1 0 1 05 06 00 23 00001234 1 0 0 1 0 0
0 37FF80A3C2 1 0 1 07 05 00 26 fffffff0 0 1 0 1 0 1
1 040000EFA0 1 0 1 1f 00 00 20 ffff8000 0 0 1 1 0 0
0 FFFFFFFF9F 1 0 1 00 00 00 2e 00000000 0 0 0 0 0 0
0 00000A217F 1 0 1 00 00 00 2e 00000000 0 0 0 0 1 0
1 007E082082 1 0 1 00 00 00 2e 00000000 0 0 0 0 1 0
0 1408102182 1 0 1 03 01 02 25 00000000 1 0 0 0 0 0
0 0000000000 0 0 0 03 01 02 25 00000000 1 0 0 0 0 0
0 0000000000 0 0 0 03 01 02 25 00000000 1 0 0 0 0 0
1 0800086409 1 0 1 08 03 00 21 00000001 1 0 0 1 0 1
0 2007F9A608 1 0 1 0c 0d 00 24 000000ff 1 0 0 1 0 0
0 1408102182 1 1 1 0c 0d 00 24 000000ff 1 0 0 1 0 0
0 0800B2AA0C 1 1 1 0c 0d 00 24 000000ff 1 0 0 1 0 0
1 000A618702 1 0 1 0e 0c 0c 20 00000000 1 0 0 0 0 1
0 1408102182 1 0 1 03 01 02 25 00000000 1 0 0 0 0 0
0 0010192202 1 0 1 04 09 03 20 00000000 1 0 0 0 0 1
0 001430A002 1 0 1 00 05 06 20 00000000 1 0 0 0 0 0
0 0018000382 1 0 1 07 00 00 20 00000000 1 0 0 0 0 0
0 007E38E382 1 0 1 00 00 00 2e 00000000 0 0 0 0 1 0
0 000838E402 1 0 1 08 07 07 20 00000000 1 0 0 0 0 0
1 0012594482 1 0 1 09 0a 0b 20 00000000 1 0 0 0 0 0

//--- verilog.f
rtl/decodePkg.sv
rtl/decodeIf.sv
rtl/decodePredReg.sv
rtl/decodeRegSpec.sv
rtl/decodeFields.sv
rtl/decodeStage.sv
rtl/decodeTop.sv
verif/decodeChecker.sv
verif/decodeTb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -f verilog.f --top-module decodeTb -o simv

run: compile
	./obj_dir/simv > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	if grep -q "Done: errors found" sim.log; then exit 1; fi; \
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
